//--- logic/fetch_settings.svh
// Width, memory depth, bubble word, jump shadow, halt drain and hazard history macros
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Instruction and address width in bits
`define FETCH_WORD_W 16

// Instruction memory depth in 16-bit words
`define FETCH_IMEM_WORDS 256

// Bubble sent down the pipe, also the reset value of instr_out
`define FETCH_NOP_WORD 16'h0800

// Nop cycles that follow an issued jump or branch
`define FETCH_JUMP_SHADOW 3

// Cycles from the first halt fetch until dump rises
`define FETCH_HALT_DRAIN 5

// In-flight destination entries kept by the hazard detector
`define FETCH_RAW_DEPTH 3

`endif

//--- logic/fetch_pkg.sv
// Instruction-word field types, field positions and opcode-class constants
package fetch_pkg;

   ////////////////////
   // Field types
   ////////////////////

   // Five-bit opcode in bits 15 to 11
   typedef logic [4:0] opcode_t;

   // Register index for rs, rt and destinations
   typedef logic [2:0] reg_idx_t;

   // Top three opcode bits select the class
   typedef logic [2:0] opc_class_t;

   // Low bit of each field in the word
   localparam int OPC_LSB = 11;
   localparam int RS_LSB  = 8;
   localparam int RT_LSB  = 5;

   ////////////////////
   // Opcode classes
   ////////////////////

   // Halt is the all-zero opcode
   localparam opcode_t OPC_HALT = 5'b00000;

   // Jumps and branches
   localparam opc_class_t JUMP_CLASS_A = 3'b001;
   localparam opc_class_t JUMP_CLASS_B = 3'b011;

   // Class with no rs source at all
   localparam opc_class_t RS_NONE_CLASS = 3'b000;
   // Class where rs is a source only when bit 11 is set
   localparam opc_class_t RS_OPT_CLASS  = 3'b001;

   // rt is read by the whole 111 class
   localparam opc_class_t RT_SRC_CLASS = 3'b111;
   // and by the four-bit prefix 1101
   localparam logic [3:0] RT_SRC_PREFIX = 4'b1101;

endpackage

//--- logic/src_check_if.sv
// Source-register check interface between issue logic and hazard detector
`timescale 1ns/10ps

interface src_check_if import fetch_pkg::*; ();

   // Sources of the word currently fetched
   reg_idx_t src1;
   reg_idx_t src2;
   // Field really read by the instruction
   logic     src1_valid;
   logic     src2_valid;

   // Hazard result, same cycle
   logic     raw;

   // Issue side sends sources, gets the verdict
   modport requester (
      output src1,
      output src2,
      output src1_valid,
      output src2_valid,
      input  raw
   );

   // Detector side
   modport detector (
      input  src1,
      input  src2,
      input  src1_valid,
      input  src2_valid,
      output raw
   );

endinterface

//--- logic/fetch_pc.sv
// Program counter register with increment by two, redirect and hold
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_pc (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     hold,
   input  logic                     pc_src,
   input  logic [`FETCH_WORD_W-1:0] jump_pc,
   output logic [`FETCH_WORD_W-1:0] pc,
   output logic [`FETCH_WORD_W-1:0] pc_plus2
);

   // Byte step between 16-bit words
   localparam logic [`FETCH_WORD_W-1:0] PC_STEP = `FETCH_WORD_W'(2);

   ////////////////////
   // Next address
   ////////////////////

   // Sequential successor, also sent down the pipe
   assign pc_plus2 = pc + PC_STEP;

   ////////////////////
   // PC register
   ////////////////////

   // Redirect beats hold, hold beats increment
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (pc_src) begin
         pc <= jump_pc;
      end else if (!hold) begin
         pc <= pc_plus2;
      end
   end

endmodule

//--- logic/instr_mem.sv
// Word-addressed instruction memory with asynchronous read and synchronous load port
`timescale 1ns/10ps
`include "fetch_settings.svh"

module instr_mem (
   input  logic                     clk,
   input  logic [`FETCH_WORD_W-1:0] addr,
   output logic [`FETCH_WORD_W-1:0] instr,
   input  logic                     wr,
   input  logic [`FETCH_WORD_W-1:0] wr_addr,
   input  logic [`FETCH_WORD_W-1:0] wr_data
);

   // Bits needed to index one word
   localparam int IDX_W = $clog2(`FETCH_IMEM_WORDS);

   // Program storage, loaded while reset is held
   logic [`FETCH_WORD_W-1:0] mem [`FETCH_IMEM_WORDS];

   // Index of the word under the PC
   logic [IDX_W-1:0] rd_idx;
   // Index of the word being loaded
   logic [IDX_W-1:0] wr_idx;

   ////////////////////
   // Read side
   ////////////////////

   // PC is a byte address, drop bit 0 to get the word
   assign rd_idx = addr[IDX_W:1];

   // Combinational fetch, word ready in the same cycle
   assign instr = mem[rd_idx];

   ////////////////////
   // Load side
   ////////////////////

   // Load port takes a word index, not a byte address
   assign wr_idx = wr_addr[IDX_W-1:0];

   always_ff @(posedge clk) begin
      if (wr) begin
         mem[wr_idx] <= wr_data;
      end
   end

endmodule

//--- logic/raw_detector.sv
// Destination-register history and read-after-write comparison against current sources
`timescale 1ns/10ps
`include "fetch_settings.svh"

module raw_detector import fetch_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   src_check_if.detector chk,
   input  reg_idx_t    dst,
   input  logic        dst_valid
);

   localparam int DEPTH = `FETCH_RAW_DEPTH;

   // Entry 0 is the youngest in-flight destination
   reg_idx_t hist_dst   [DEPTH];
   logic     hist_valid [DEPTH];

   // Any valid source matching any valid entry
   logic     raw_hit;

   ////////////////////
   // History shift
   ////////////////////

   // Valid flags are control state, cleared on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < DEPTH; i++) begin
            hist_valid[i] <= 1'b0;
         end
      end else begin
         hist_valid[0] <= dst_valid;
         for (int i = 1; i < DEPTH; i++) begin
            hist_valid[i] <= hist_valid[i-1];
         end
      end
   end

   // Register numbers just ride along with their flags
   always_ff @(posedge clk) begin
      hist_dst[0] <= dst;
      for (int i = 1; i < DEPTH; i++) begin
         hist_dst[i] <= hist_dst[i-1];
      end
   end

   ////////////////////
   // Compare
   ////////////////////

   always_comb begin
      raw_hit = 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
         if (hist_valid[i]) begin
            // rs against this entry
            if (chk.src1_valid && (chk.src1 == hist_dst[i])) begin
               raw_hit = 1'b1;
            end
            // rt against this entry
            if (chk.src2_valid && (chk.src2 == hist_dst[i])) begin
               raw_hit = 1'b1;
            end
         end
      end
   end

   // Verdict back to the issue block in the same cycle
   assign chk.raw = raw_hit;

endmodule

//--- logic/fetch_issue.sv
// Opcode decode, bubble insertion, jump shadow, halt drain and output pipe registers
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_issue import fetch_pkg::*; (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [`FETCH_WORD_W-1:0] instr,
   input  logic [`FETCH_WORD_W-1:0] pc_plus2,
   input  logic                     pc_src,
   src_check_if.requester           chk,
   output logic                     hold,
   output logic [`FETCH_WORD_W-1:0] instr_out,
   output logic [`FETCH_WORD_W-1:0] incr_pc,
   output logic                     dump
);

   localparam int SHADOW_W = $clog2(`FETCH_JUMP_SHADOW + 1);
   localparam int DRAIN_W  = $clog2(`FETCH_HALT_DRAIN + 1);
   localparam logic [SHADOW_W-1:0]      SHADOW_LOAD = SHADOW_W'(`FETCH_JUMP_SHADOW);
   localparam logic [DRAIN_W-1:0]       DRAIN_DONE  = DRAIN_W'(`FETCH_HALT_DRAIN);
   localparam logic [`FETCH_WORD_W-1:0] NOP_WORD    = `FETCH_NOP_WORD;

   // Decoded fields of the fetched word
   opcode_t    opcode;
   opc_class_t opc_class;
   logic       halt_fetched;
   logic       jump_fetched;

   // Jump shadow down-counter
   logic [SHADOW_W-1:0] shadow_cnt;
   logic                shadow_active;

   // Halt drain counter, saturates at dump
   logic [DRAIN_W-1:0]  drain_cnt;
   logic                halted;

   // Result of the priority mux
   logic                     jump_issue;
   logic [`FETCH_WORD_W-1:0] issue_word;

   ////////////////////
   // Opcode decode
   ////////////////////

   assign opcode    = instr[OPC_LSB +: $bits(opcode_t)];
   assign opc_class = opcode[4:2];

   assign halt_fetched = (opcode == OPC_HALT);
   assign jump_fetched = (opc_class == JUMP_CLASS_A) || (opc_class == JUMP_CLASS_B);

   // Source fields at fixed positions
   assign chk.src1 = instr[RS_LSB +: $bits(reg_idx_t)];
   assign chk.src2 = instr[RT_LSB +: $bits(reg_idx_t)];

   // rs unused by class 000, and by class 001 when bit 11 is clear
   assign chk.src1_valid = (opc_class != RS_NONE_CLASS) &&
                           !((opc_class == RS_OPT_CLASS) && !opcode[0]);

   // rt read only by prefix 1101 and class 111
   assign chk.src2_valid = (opcode[4:1] == RT_SRC_PREFIX) || (opc_class == RT_SRC_CLASS);

   ////////////////////
   // Issue priority
   ////////////////////

   assign shadow_active = (shadow_cnt != '0);
   assign halted        = (drain_cnt != '0);

   always_comb begin
      issue_word = instr;
      hold       = 1'b0;
      jump_issue = 1'b0;
      if (halt_fetched || halted) begin
         // Halt wins, PC parks on it for good
         hold = 1'b1;
      end else if (shadow_active) begin
         // Fetched word is the stale jump, send a bubble instead
         issue_word = NOP_WORD;
         // Step past the jump on the last shadow cycle
         hold       = (shadow_cnt != 1);
      end else if (chk.raw) begin
         // Stall until the producer leaves the history
         issue_word = NOP_WORD;
         hold       = 1'b1;
      end else if (jump_fetched) begin
         // Jump goes out once, then the shadow starts
         hold       = 1'b1;
         jump_issue = 1'b1;
      end
   end

   ////////////////////
   // Shadow and drain
   ////////////////////

   // Redirect ends the shadow early
   always_ff @(posedge clk) begin
      if (reset) begin
         shadow_cnt <= '0;
      end else if (pc_src) begin
         shadow_cnt <= '0;
      end else if (shadow_active) begin
         shadow_cnt <= shadow_cnt - 1'b1;
      end else if (jump_issue) begin
         shadow_cnt <= SHADOW_LOAD;
      end
   end

   // Starts on the first halt fetch, keeps counting to the drain length
   always_ff @(posedge clk) begin
      if (reset) begin
         drain_cnt <= '0;
      end else if ((halt_fetched || halted) && (drain_cnt != DRAIN_DONE)) begin
         drain_cnt <= drain_cnt + 1'b1;
      end
   end

   // High once the halt has drained, stays until reset
   assign dump = (drain_cnt == DRAIN_DONE);

   ////////////////////
   // Output pipe
   ////////////////////

   // Frozen once halted, so the halt word repeats
   always_ff @(posedge clk) begin
      if (reset) begin
         instr_out <= NOP_WORD;
         incr_pc   <= '0;
      end else if (!halted) begin
         instr_out <= issue_word;
         incr_pc   <= pc_plus2;
      end
   end

endmodule

//--- logic/fetch_stage.sv
// Fetch stage top level with PC, instruction memory, hazard detector and issue block
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_stage import fetch_pkg::*; (
   input  logic                     clk,
   input  logic                     reset,
   // Redirect from later stages
   input  logic                     pc_src,
   input  logic [`FETCH_WORD_W-1:0] jump_pc,
   // Destination of the word issued a cycle earlier
   input  reg_idx_t                 dst,
   input  logic                     dst_valid,
   // Program load port
   input  logic                     imem_wr,
   input  logic [`FETCH_WORD_W-1:0] imem_addr,
   input  logic [`FETCH_WORD_W-1:0] imem_data,
   // Toward decode
   output logic [`FETCH_WORD_W-1:0] incr_pc,
   output logic [`FETCH_WORD_W-1:0] instr_out,
   output logic                     dump
);

   // PC and its increment
   logic [`FETCH_WORD_W-1:0] pc;
   logic [`FETCH_WORD_W-1:0] pc_plus2;
   // Word under the PC
   logic [`FETCH_WORD_W-1:0] instr;
   // Stall request from issue
   logic                     hold;

   // Sources out, hazard verdict back
   src_check_if chk_if ();

   fetch_pc u_pc (
      .clk      (clk),
      .reset    (reset),
      .hold     (hold),
      .pc_src   (pc_src),
      .jump_pc  (jump_pc),
      .pc       (pc),
      .pc_plus2 (pc_plus2)
   );

   instr_mem u_imem (
      .clk     (clk),
      .addr    (pc),
      .instr   (instr),
      .wr      (imem_wr),
      .wr_addr (imem_addr),
      .wr_data (imem_data)
   );

   raw_detector u_raw (
      .clk       (clk),
      .reset     (reset),
      .chk       (chk_if.detector),
      .dst       (dst),
      .dst_valid (dst_valid)
   );

   fetch_issue u_issue (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .pc_plus2  (pc_plus2),
      .pc_src    (pc_src),
      .chk       (chk_if.requester),
      .hold      (hold),
      .instr_out (instr_out),
      .incr_pc   (incr_pc),
      .dump      (dump)
   );

endmodule

//--- testbench/fetch_stage_checker.sv
// Bound assertions on the fetch stage top-level ports
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_stage_checker (
   input logic                     clk,
   input logic                     reset,
   input logic                     pc_src,
   input logic [`FETCH_WORD_W-1:0] instr_out,
   input logic [`FETCH_WORD_W-1:0] incr_pc,
   input logic                     dump
);

   // Failed assertions so far, polled by the testbench
   int unsigned err_count = 0;

   // Dump is sticky once out of reset
   dump_sticky: assert property (@(posedge clk) !reset |-> !$fell(dump))
      else begin
         $error("dump fell while reset was low");
         err_count++;
      end

   // Output pipe parked on the bubble
   nop_in_reset: assert property (@(posedge clk)
      (reset && $past(reset)) |-> (instr_out == `FETCH_NOP_WORD))
      else begin
         $error("instr_out is not the nop word during reset");
         err_count++;
      end

   // Nothing moves after the drain unless redirected
   incr_frozen: assert property (@(posedge clk) disable iff (reset)
      (!pc_src && dump) |-> $stable(incr_pc))
      else begin
         $error("incr_pc changed while dump was high");
         err_count++;
      end

endmodule

bind fetch_stage fetch_stage_checker u_chk (
   .clk       (clk),
   .reset     (reset),
   .pc_src    (pc_src),
   .instr_out (instr_out),
   .incr_pc   (incr_pc),
   .dump      (dump)
);

//--- testbench/fetch_stage_tb.sv
// Fetch stage testbench with clock, reset, program load and per-cycle checks from the stim file
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_stage_tb import fetch_pkg::*; ();

   localparam int WORD_W     = `FETCH_WORD_W;
   localparam int STIM_WORDS = 1024;
   localparam int FIELDS     = 7;
   // One program word per reset cycle
   localparam int PROG_SLOTS = 10;
   localparam int MAX_CYCLES = 100;
   localparam int DUMP_WAIT  = 20;

   logic              clk = 1'b0;
   logic              reset;
   logic              pc_src;
   logic [WORD_W-1:0] jump_pc;
   reg_idx_t          dst;
   logic              dst_valid;
   logic              imem_wr;
   logic [WORD_W-1:0] imem_addr;
   logic [WORD_W-1:0] imem_data;
   logic [WORD_W-1:0] incr_pc;
   logic [WORD_W-1:0] instr_out;
   logic              dump;

   // Program image, then the per-cycle records
   logic [WORD_W-1:0] stim [STIM_WORDS];

   always #50 clk = ~clk;

   fetch_stage uut (
      .clk       (clk),
      .reset     (reset),
      .pc_src    (pc_src),
      .jump_pc   (jump_pc),
      .dst       (dst),
      .dst_valid (dst_valid),
      .imem_wr   (imem_wr),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .incr_pc   (incr_pc),
      .instr_out (instr_out),
      .dump      (dump)
   );

   ////////////////////
   // Helpers
   ////////////////////

   task automatic stop_run();
      $display("Test FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [WORD_W-1:0] actual,
                              input logic [WORD_W-1:0] expected);
      if (actual !== expected) begin
         $display("FAILED at %t: %s is %h, expected %h", $time, name, actual, expected);
         stop_run();
      end
   endtask

   // Done condition after the halt, bounded
   task automatic wait_dump_high(input int max_cycles);
      int n;
      n = 0;
      while ((dump !== 1'b1) && (n < max_cycles)) begin
         @(posedge clk);
         #5;
         n++;
      end
      if (dump !== 1'b1) begin
         $display("Timed out after %0d cycles waiting for dump", max_cycles);
         stop_run();
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      int prog_len;
      int cycles;
      int rec_base;
      int base;
      $timeformat(-9, 0, " ns", 0);
      reset     = 1'b1;
      pc_src    = 1'b0;
      jump_pc   = '0;
      dst       = '0;
      dst_valid = 1'b0;
      imem_wr   = 1'b0;
      imem_addr = '0;
      imem_data = '0;
      $readmemh("testbench/fetch_stim.mem", stim);
      if ($isunknown(stim[0]) || (stim[0] > PROG_SLOTS)) begin
         $display("Stimulus file has no usable program length");
         stop_run();
      end
      prog_len = int'(stim[0]);
      rec_base = prog_len + 2;
      if ($isunknown(stim[prog_len + 1]) || (stim[prog_len + 1] > MAX_CYCLES)) begin
         $display("Stimulus file has no usable cycle count");
         stop_run();
      end
      cycles = int'(stim[prog_len + 1]);
      // Load port takes word indices, one write per reset cycle
      for (int i = 0; i < PROG_SLOTS; i++) begin
         imem_wr   = (i < prog_len);
         imem_addr = WORD_W'(i);
         imem_data = stim[1 + i];
         @(posedge clk);
         #5;
      end
      reset   = 1'b0;
      imem_wr = 1'b0;
      // Record k drives cycle k, outputs sampled just before its closing edge
      for (int k = 0; k < cycles; k++) begin
         base = rec_base + k * FIELDS;
         if ($isunknown(stim[base + FIELDS - 1])) begin
            $display("Stimulus file ends before cycle %0d", k);
            stop_run();
         end
         pc_src    = stim[base][0];
         jump_pc   = stim[base + 1];
         dst       = stim[base + 2][2:0];
         dst_valid = stim[base + 3][0];
         #90;
         check_value("instr_out", instr_out, stim[base + 4]);
         check_value("incr_pc", incr_pc, stim[base + 5]);
         check_value("dump", WORD_W'(dump), stim[base + 6]);
         if (uut.u_chk.err_count != 0) begin
            $display("A bound assertion failed in cycle %0d", k);
            stop_run();
         end
         @(posedge clk);
         #5;
      end
      pc_src    = 1'b0;
      dst_valid = 1'b0;
      wait_dump_high(DUMP_WAIT);
      if (uut.u_chk.err_count == 0) begin
         $display("Test OK");
         $finish;
      end else begin
         $display("A bound assertion failed after the last record");
         stop_run();
      end
   end

endmodule

//--- testbench/fetch_stim.mem
// Program: word count, then the words for word index 0 upward
// Cycles: count, then pc_src jump_pc dst dst_valid exp_instr_out exp_incr_pc exp_dump
000a
d940 8300 dca0 8200 2400 8600 6700 8100 da60 0000
0017
0 0000 0 0 0800 0000 0  // Reset values
0 0000 4 1 d940 0002 0
0 0000 1 1 8300 0004 0
0 0000 0 0 0800 0006 0  // r4 still in flight, bubble
0 0000 0 0 0800 0006 0
0 0000 0 0 0800 0006 0
0 0000 4 1 dca0 0006 0
0 0000 0 0 8200 0008 0
0 0000 0 0 2400 000a 0  // Jump with r4 in rs field, no stall
0 0000 0 0 0800 000a 0
0 0000 0 0 0800 000a 0
0 0000 0 0 0800 000a 0
0 0000 6 1 8600 000c 0
1 0010 0 0 6700 000e 0  // Redirect inside the shadow
0 0000 0 0 0800 000e 0
0 0000 5 1 da60 0012 0
0 0000 0 0 0000 0014 0  // Halt fetched one cycle earlier
0 0000 0 0 0000 0014 0
0 0000 0 0 0000 0014 0
0 0000 0 0 0000 0014 0
0 0000 0 0 0000 0014 1  // Drain done
0 0000 0 0 0000 0014 1
0 0000 0 0 0000 0014 1

//--- fetch_stage.f
+incdir+logic
logic/fetch_pkg.sv
logic/src_check_if.sv
logic/fetch_pc.sv
logic/instr_mem.sv
logic/raw_detector.sv
logic/fetch_issue.sv
logic/fetch_stage.sv
testbench/fetch_stage_checker.sv
testbench/fetch_stage_tb.sv

//--- Makefile
TOP := fetch_stage_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f fetch_stage.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
